// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - common

sources:
  - common/rv_inst_pkg.sv
  - logic/store_data_fwd.sv
  - logic/store_align.sv
  - logic/load_align.sv
  - logic/wb_select.sv
  - mem_stage/mem_pipe_reg.sv
  - mem_stage/mem_stage_top.sv
  - target: simulation
    files:
      - sim/mem_stage_props.sv
      - sim/mem_stage_tb.sv

// ==== common/mem_stage_params.svh ====
// memory-access stage parameters
// widths, internal op codes from execute, riscv major opcodes and lane sizes

`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// ****************************************
// widths
// ****************************************
`define XLEN        64          // data and address
`define ILEN        32          // instruction word
`define OP_W        24          // internal op code from execute
`define STRB_W      8           // byte lanes per doubleword
`define REG_IDX_W   5           // register file index

// lane sizes in bits
`define BYTE_W      8
`define HALF_W      16
`define WORD_W      32

// ****************************************
// internal op codes
// ****************************************
// loads
`define OP_LB       24'd11
`define OP_LH       24'd12
`define OP_LW       24'd13
`define OP_LBU      24'd14
`define OP_LHU      24'd15
`define OP_LWU      24'd41
`define OP_LD       24'd42

// stores
`define OP_SB       24'd16
`define OP_SH       24'd17
`define OP_SW       24'd18
`define OP_SD       24'd43

// jumps, rd gets pc+4
`define OP_JAL      24'd4
`define OP_JALR     24'h300

// csr, rd gets the operand
`define OP_CSRRW    24'd49
`define OP_CSRRS    24'd50

// alu class, rd gets the alu result
`define OP_ALU_4000     24'h4000
`define OP_ALU_5000     24'h5000
`define OP_ALU_6000     24'h6000
`define OP_ALU_7000     24'h7000
`define OP_ALU_8000     24'h8000
`define OP_ALU_9000     24'h9000
`define OP_ALU_10000    24'h10000
`define OP_ALU_12000    24'h12000
`define OP_ALU_13000    24'h13000
`define OP_ALU_14000    24'h14000
`define OP_ALU_15000    24'h15000
`define OP_ALU_16000    24'h16000
`define OP_ALU_17000    24'h17000
`define OP_ALU_18000    24'h18000
`define OP_ALU_19000    24'h19000
`define OP_ALU_1A000    24'h1a000
`define OP_ALU_1B000    24'h1b000
`define OP_ALU_1D000    24'h1d000
`define OP_ALU_21000    24'h21000
`define OP_ALU_22000    24'h22000
`define OP_ALU_24000    24'h24000
`define OP_ALU_25000    24'h25000
`define OP_ALU_26000    24'h26000
`define OP_ALU_27000    24'h27000
`define OP_ALU_28000    24'h28000
`define OP_ALU_29000    24'h29000
`define OP_ALU_LUI      24'h100
`define OP_ALU_AUIPC    24'h200
`define OP_ALU_400      24'h400
`define OP_ALU_800      24'h800
`define OP_ALU_C00      24'hc00
`define OP_ALU_D19      24'd19
`define OP_ALU_D20      24'd20
`define OP_ALU_D21      24'd21
`define OP_ALU_D22      24'd22
`define OP_ALU_D23      24'd23
`define OP_ALU_D24      24'd24
`define OP_ALU_D47      24'd47

// ****************************************
// riscv major opcodes
// ****************************************
`define RV_LOAD     7'b0000011
`define RV_STORE    7'b0100011
`define RV_OP_IMM   7'b0010011
`define RV_OP_IMM32 7'b0011011
`define RV_OP       7'b0110011
`define RV_OP32     7'b0111011
`define RV_LUI      7'b0110111
`define RV_AUIPC    7'b0010111
`define RV_SYSTEM   7'b1110011

// system funct3 that write rd
`define F3_CSRRW    3'b001
`define F3_CSRRS    3'b010

`endif

// ==== common/rv_inst_pkg.sv ====
// riscv instruction word type
// one 32-bit word seen as an r/i-type layout or an s-type layout

package rv_inst_pkg;

    // r/i view, rd sits in [11:7]
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } wr_fmt_t;

    // s view, same bits hold the split immediate
    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        logic [4:0] rs2;        // store source
        logic [4:0] rs1;        // base
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        logic [6:0] opcode;
    } st_fmt_t;

    typedef union packed {
        wr_fmt_t wr;
        st_fmt_t st;
    } inst_t;

endpackage

// ==== list.f ====
+incdir+common
common/rv_inst_pkg.sv
logic/store_data_fwd.sv
logic/store_align.sv
logic/load_align.sv
logic/wb_select.sv
mem_stage/mem_pipe_reg.sv
mem_stage/mem_stage_top.sv
sim/mem_stage_props.sv
sim/mem_stage_tb.sv

// ==== logic/load_align.sv ====
// load lane extraction
// picks the addressed byte/half/word from the doubleword and extends it

`include "mem_stage_params.svh"

module load_align (
    input  logic [`OP_W-1:0]    st_op,
    input  logic [2:0]          addr_low,
    input  logic [`XLEN-1:0]    mem_rdata,
    output logic [`XLEN-1:0]    load_data
);

    logic [`XLEN-1:0]   shifted;        // addressed byte moved to lane 0
    logic [`BYTE_W-1:0] rd_byte;
    logic [`HALF_W-1:0] rd_half;
    logic [`WORD_W-1:0] rd_word;

    assign shifted = mem_rdata >> {addr_low, 3'b000};
    assign rd_byte = shifted[`BYTE_W-1:0];
    assign rd_half = addr_low[0] ? {`HALF_W{1'b0}} : shifted[`HALF_W-1:0];    // even only
    assign rd_word = addr_low[2] ? mem_rdata[`XLEN-1:`WORD_W]
                                 : mem_rdata[`WORD_W-1:0];

    // ****************************************
    // extension by op
    // ****************************************
    always_comb begin
        case (st_op)
            `OP_LB:  load_data = {{(`XLEN-`BYTE_W){rd_byte[`BYTE_W-1]}}, rd_byte};
            `OP_LH:  load_data = {{(`XLEN-`HALF_W){rd_half[`HALF_W-1]}}, rd_half};
            `OP_LW:  load_data = {{(`XLEN-`WORD_W){rd_word[`WORD_W-1]}}, rd_word};
            `OP_LBU: load_data = {{(`XLEN-`BYTE_W){1'b0}}, rd_byte};
            `OP_LHU: load_data = {{(`XLEN-`HALF_W){1'b0}}, rd_half};
            `OP_LWU: load_data = {{(`XLEN-`WORD_W){1'b0}}, rd_word};
            `OP_LD:  load_data = mem_rdata;                 // whole doubleword
            default: load_data = {`XLEN{1'b0}};
        endcase
    end

endmodule

// ==== logic/store_align.sv ====
// store lane alignment
// places store data in its doubleword lane and builds the byte strobe

`include "mem_stage_params.svh"

module store_align (
    input  logic [`OP_W-1:0]    st_op,
    input  logic [2:0]          addr_low,
    input  logic [`XLEN-1:0]    fwd_src2,
    output logic [`XLEN-1:0]    mem_wdata,
    output logic [`STRB_W-1:0]  mem_wstrb
);

    logic [`XLEN-1:0]   byte_word;      // low byte, zero extended
    logic [`XLEN-1:0]   half_word;      // low half, zero extended
    logic [`XLEN-1:0]   word_lo;        // low word, zero extended
    logic [5:0]         bit_shift;      // byte offset in bits

    assign byte_word = {{(`XLEN-`BYTE_W){1'b0}}, fwd_src2[`BYTE_W-1:0]};
    assign half_word = {{(`XLEN-`HALF_W){1'b0}}, fwd_src2[`HALF_W-1:0]};
    assign word_lo   = {{(`XLEN-`WORD_W){1'b0}}, fwd_src2[`WORD_W-1:0]};
    assign bit_shift = {addr_low, 3'b000};

    always_comb begin
        mem_wdata = {`XLEN{1'b0}};
        mem_wstrb = {`STRB_W{1'b0}};
        case (st_op)
            `OP_SB: begin
                mem_wdata = byte_word << bit_shift;
                mem_wstrb = 8'h01 << addr_low;
            end
            `OP_SH: begin
                if (!addr_low[0]) begin         // odd offset stays all zero
                    mem_wdata = half_word << bit_shift;
                    mem_wstrb = 8'h03 << addr_low;
                end
            end
            `OP_SW: begin
                mem_wdata = addr_low[2] ? (word_lo << `WORD_W) : word_lo;   // bit 2 picks the half
                mem_wstrb = addr_low[2] ? 8'hf0 : 8'h0f;
            end
            `OP_SD: begin
                mem_wdata = fwd_src2;
                mem_wstrb = {`STRB_W{1'b1}};
            end
            default: begin
                // not a store, port stays quiet
                mem_wdata = {`XLEN{1'b0}};
                mem_wstrb = {`STRB_W{1'b0}};
            end
        endcase
    end

endmodule

// ==== logic/store_data_fwd.sv ====
// store operand forwarding
// takes the writeback result when it targets the store's rs2

`include "mem_stage_params.svh"

module store_data_fwd (
    input  logic                st_valid,
    input  rv_inst_pkg::inst_t  st_inst,
    input  logic [`XLEN-1:0]    st_src2,
    input  logic                wb_valid,
    input  rv_inst_pkg::inst_t  wb_inst,
    input  logic [`XLEN-1:0]    wb_wdata,
    output logic [`XLEN-1:0]    fwd_src2
);

    logic st_is_store;
    logic wb_writes_rd;
    logic rs2_match;

    assign st_is_store = st_valid && (st_inst.st.opcode == `RV_STORE);

    // writeback classes that update rd, jal/jalr left out
    always_comb begin
        case (wb_inst.wr.opcode)
            `RV_LOAD,
            `RV_OP_IMM,
            `RV_OP_IMM32,
            `RV_OP,
            `RV_OP32,
            `RV_LUI,
            `RV_AUIPC:   wb_writes_rd = 1'b1;
            `RV_SYSTEM:  wb_writes_rd = (wb_inst.wr.funct3 == `F3_CSRRW) ||
                                        (wb_inst.wr.funct3 == `F3_CSRRS);   // csrrw/csrrs
            default:     wb_writes_rd = 1'b0;
        endcase
    end

    // x0 never forwards
    assign rs2_match = (wb_inst.wr.rd == st_inst.st.rs2) && (st_inst.st.rs2 != 5'd0);

    assign fwd_src2 = (st_is_store && wb_valid && wb_writes_rd && rs2_match) ? wb_wdata
                                                                             : st_src2;

endmodule

// ==== logic/wb_select.sv ====
// register write select
// chooses enable and value: alu result, pc+4, csr operand or load data

`include "mem_stage_params.svh"

module wb_select (
    input  logic                    st_valid,
    input  logic                    blocked,
    input  logic [`OP_W-1:0]        st_op,
    input  rv_inst_pkg::inst_t      st_inst,
    input  logic [`XLEN-1:0]        st_pc,
    input  logic [`XLEN-1:0]        st_alu,
    input  logic [`XLEN-1:0]        st_src2,
    input  logic [`XLEN-1:0]        load_data,
    output logic                    rd_we,
    output logic [`REG_IDX_W-1:0]   rd_idx,
    output logic [`XLEN-1:0]        rd_wdata
);

    logic               wen;
    logic [`XLEN-1:0]   wdata;
    logic               live;           // stage holds a finished op

    always_comb begin
        wen   = 1'b1;
        wdata = {`XLEN{1'b0}};
        case (st_op)
            `OP_ALU_4000, `OP_ALU_5000, `OP_ALU_6000, `OP_ALU_7000, `OP_ALU_8000,
            `OP_ALU_9000, `OP_ALU_10000, `OP_ALU_12000, `OP_ALU_13000, `OP_ALU_14000,
            `OP_ALU_15000, `OP_ALU_16000, `OP_ALU_17000, `OP_ALU_18000, `OP_ALU_19000,
            `OP_ALU_1A000, `OP_ALU_1B000, `OP_ALU_1D000, `OP_ALU_21000, `OP_ALU_22000,
            `OP_ALU_24000, `OP_ALU_25000, `OP_ALU_26000, `OP_ALU_27000, `OP_ALU_28000,
            `OP_ALU_29000, `OP_ALU_LUI, `OP_ALU_AUIPC, `OP_ALU_400, `OP_ALU_800,
            `OP_ALU_C00, `OP_ALU_D19, `OP_ALU_D20, `OP_ALU_D21, `OP_ALU_D22,
            `OP_ALU_D23, `OP_ALU_D24, `OP_ALU_D47:
                wdata = st_alu;
            `OP_JAL, `OP_JALR:
                wdata = st_pc + 64'd4;      // link address
            `OP_CSRRW, `OP_CSRRS:
                wdata = st_src2;            // old csr value from execute
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWU, `OP_LD:
                wdata = load_data;
            default:
                wen = 1'b0;                 // stores, branches, nops
        endcase
    end

    assign live     = st_valid && !blocked;
    assign rd_we    = live && wen;
    assign rd_idx   = live ? st_inst.wr.rd : {`REG_IDX_W{1'b0}};
    assign rd_wdata = live ? wdata : {`XLEN{1'b0}};

endmodule

// ==== mem_stage/mem_pipe_reg.sv ====
// stage register between execute and memory access
// holds one instruction, raises the memory request and stalls until ack

`include "mem_stage_params.svh"

module mem_pipe_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [`XLEN-1:0]    in_pc,
    input  rv_inst_pkg::inst_t  in_inst,
    input  logic [`OP_W-1:0]    in_op,
    input  logic [`XLEN-1:0]    in_alu,
    input  logic [`XLEN-1:0]    in_src2,
    input  logic                out_ready,
    input  logic                mem_ack,
    output logic                in_ready,
    output logic                out_valid,
    output logic [`XLEN-1:0]    out_pc,
    output rv_inst_pkg::inst_t  out_inst,
    output logic                st_valid,
    output logic [`XLEN-1:0]    st_pc,
    output rv_inst_pkg::inst_t  st_inst,
    output logic [`OP_W-1:0]    st_op,
    output logic [`XLEN-1:0]    st_alu,
    output logic [`XLEN-1:0]    st_src2,
    output logic                blocked,
    output logic                mem_req,
    output logic                mem_we,
    output logic [`XLEN-1:0]    mem_addr
);

    logic is_load;
    logic is_store;

    // ****************************************
    // stage register
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid <= 1'b0;
        end else if (in_ready) begin
            st_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin             // hold under stall or back-pressure
            st_pc   <= in_pc;
            st_inst <= in_inst;
            st_op   <= in_op;
            st_alu  <= in_alu;
            st_src2 <= in_src2;
        end
    end

    // ****************************************
    // memory request and stall
    // ****************************************
    assign is_load  = st_op inside {`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWU, `OP_LD};
    assign is_store = st_op inside {`OP_SB, `OP_SH, `OP_SW, `OP_SD};

    assign mem_req  = st_valid && (is_load || is_store);   // held until ack
    assign mem_we   = st_valid && is_store;
    assign mem_addr = st_alu;                               // full address, lane from [2:0]

    assign blocked  = mem_req && !mem_ack;

    // outputs hidden while the access is in flight
    assign in_ready  = blocked ? 1'b0 : out_ready;
    assign out_valid = st_valid && !blocked;
    assign out_pc    = blocked ? {`XLEN{1'b0}} : st_pc;
    assign out_inst  = blocked ? rv_inst_pkg::inst_t'({`ILEN{1'b0}}) : st_inst;

endmodule

// ==== mem_stage/mem_stage_top.sv ====
// memory-access stage of the 64-bit pipeline
// stage register, store forwarding, lane alignment and register write select

`include "mem_stage_params.svh"

module mem_stage_top (
    input  logic                    clk,
    input  logic                    rst,
    // from execute
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [`XLEN-1:0]        in_pc,
    input  rv_inst_pkg::inst_t      in_inst,
    input  logic [`OP_W-1:0]        in_op,
    input  logic [`XLEN-1:0]        in_alu,
    input  logic [`XLEN-1:0]        in_src2,
    // to writeback
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [`XLEN-1:0]        out_pc,
    output rv_inst_pkg::inst_t      out_inst,
    // register file write
    output logic                    rd_we,
    output logic [`REG_IDX_W-1:0]   rd_idx,
    output logic [`XLEN-1:0]        rd_wdata,
    // writeback feedback
    input  logic                    wb_valid,
    input  rv_inst_pkg::inst_t      wb_inst,
    input  logic [`XLEN-1:0]        wb_wdata,
    // memory port
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [`XLEN-1:0]        mem_addr,
    output logic [`XLEN-1:0]        mem_wdata,
    output logic [`STRB_W-1:0]      mem_wstrb,
    input  logic                    mem_ack,
    input  logic [`XLEN-1:0]        mem_rdata
);

    // registered stage fields
    logic                   st_valid;
    logic [`XLEN-1:0]       st_pc;
    rv_inst_pkg::inst_t     st_inst;
    logic [`OP_W-1:0]       st_op;
    logic [`XLEN-1:0]       st_alu;
    logic [`XLEN-1:0]       st_src2;
    logic                   blocked;    // mem op waiting on ack

    logic [`XLEN-1:0]       fwd_src2;   // store operand after forwarding
    logic [`XLEN-1:0]       load_data;  // extended load result

    mem_pipe_reg i_pipe_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pc     (in_pc),
        .in_inst   (in_inst),
        .in_op     (in_op),
        .in_alu    (in_alu),
        .in_src2   (in_src2),
        .out_ready (out_ready),
        .mem_ack   (mem_ack),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .st_valid  (st_valid),
        .st_pc     (st_pc),
        .st_inst   (st_inst),
        .st_op     (st_op),
        .st_alu    (st_alu),
        .st_src2   (st_src2),
        .blocked   (blocked),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr)
    );

    store_data_fwd i_store_fwd (
        .st_valid (st_valid),
        .st_inst  (st_inst),
        .st_src2  (st_src2),
        .wb_valid (wb_valid),
        .wb_inst  (wb_inst),
        .wb_wdata (wb_wdata),
        .fwd_src2 (fwd_src2)
    );

    // low address bits pick the lane
    store_align i_store_align (
        .st_op     (st_op),
        .addr_low  (st_alu[2:0]),
        .fwd_src2  (fwd_src2),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb)
    );

    load_align i_load_align (
        .st_op     (st_op),
        .addr_low  (st_alu[2:0]),
        .mem_rdata (mem_rdata),
        .load_data (load_data)
    );

    wb_select i_wb_select (
        .st_valid  (st_valid),
        .blocked   (blocked),
        .st_op     (st_op),
        .st_inst   (st_inst),
        .st_pc     (st_pc),
        .st_alu    (st_alu),
        .st_src2   (st_src2),    // csr ops take the unforwarded operand
        .load_data (load_data),
        .rd_we     (rd_we),
        .rd_idx    (rd_idx),
        .rd_wdata  (rd_wdata)
    );

endmodule

// ==== sim/mem_stage_props.sv ====
// memory stage protocol checks
// request stability, stall gating, reset state and back-pressure

module mem_stage_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     mem_req,
    input logic                     mem_ack,
    input logic                     mem_we,
    input logic [63:0]              mem_addr,
    input logic [63:0]              mem_wdata,
    input logic [7:0]               mem_wstrb,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic                     in_ready,
    input logic                     rd_we
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // failed assertions so far

    // pending request keeps every field until ack
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we)
                                && $stable(mem_wdata) && $stable(mem_wstrb))
        else begin
            $error("memory request changed before ack");
            fail_cnt++;
        end

    a_blocked_quiet: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |-> !out_valid && !in_ready)
        else begin
            $error("stage presented output while waiting on memory");
            fail_cnt++;
        end

    a_reset_state: assert property (@(posedge clk)
        rst |=> !rd_we && !mem_req && !out_valid)
        else begin
            $error("outputs active right after reset");
            fail_cnt++;
        end

    a_backpressure: assert property (@(posedge clk) disable iff (rst)
        !out_ready |-> !in_ready)
        else begin
            $error("input accepted under back-pressure");
            fail_cnt++;
        end

endmodule

bind mem_stage_top mem_stage_props i_props (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .rd_we     (rd_we)
);

// ==== sim/mem_stage_tb.sv ====
// memory stage testbench
// replays the trace, answers memory requests and checks the results

`include "mem_stage_params.svh"

module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_DLY = 3;     // longest ack delay, random ones included
    localparam int MAX_BP  = 3;     // longest back-pressure in the trace
    localparam int RND_DLY = 255;   // trace marker for a random delay

    typedef struct {
        int                     id;
        logic [`OP_W-1:0]       op;
        rv_inst_pkg::inst_t     inst;
        logic [`XLEN-1:0]       pc, alu, src2;
        logic                   wbv;
        rv_inst_pkg::inst_t     wbinst;
        logic [`XLEN-1:0]       wbdata, rdata;
        int                     dly, bp;
        logic                   we;
        logic [`XLEN-1:0]       wdata, mwdata;
        logic [`STRB_W-1:0]     strb;
    } trace_t;

    logic clk, rst, in_valid, in_ready, out_valid, out_ready, rd_we, wb_valid;
    logic mem_req, mem_we, mem_ack;
    logic [`XLEN-1:0] in_pc, in_alu, in_src2, out_pc, rd_wdata, wb_wdata;
    logic [`XLEN-1:0] mem_addr, mem_wdata, mem_rdata;
    logic [`OP_W-1:0] in_op;
    logic [`REG_IDX_W-1:0] rd_idx;
    logic [`STRB_W-1:0] mem_wstrb;
    rv_inst_pkg::inst_t in_inst, out_inst, wb_inst;

    trace_t ops[$];
    integer seed = 32'hc8c7;
    int     err_cnt = 0;
    int     bad_tests = 0;
    bit     trace_loaded = 0;

    mem_stage_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    // checks failed so far, bound assertions included
    function automatic int total_errors();
        return err_cnt + i_dut.i_props.fail_cnt;
    endfunction

    // loads and stores by the major opcode of the traced instruction
    function automatic logic is_mem_access(input rv_inst_pkg::inst_t inst);
        return inst.wr.opcode inside {`RV_LOAD, `RV_STORE};
    endfunction

    // ****************************************
    // compare tasks
    // ****************************************
    task automatic check_word(input string name, input logic [`XLEN-1:0] act, exp);
        if (act !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_strb(input string name, input logic [`STRB_W-1:0] act, exp);
        if (act !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_idx(input string name, input logic [`REG_IDX_W-1:0] act,
                             input rv_inst_pkg::inst_t exp_inst);
        if (act !== exp_inst.wr.rd) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, act, exp_inst.wr.rd);
            err_cnt++;
        end
    endtask

    task automatic check_inst(input string name, input rv_inst_pkg::inst_t act, exp);
        if (act !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic act, exp);
        if (act !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, act, exp);
            err_cnt++;
        end
    endtask

    // ****************************************
    // trace reader
    // ****************************************
    task automatic load_trace(output bit ok);
        int fd;
        int n;
        string line;
        trace_t t;
        logic [31:0] inst_w, wbinst_w;
        ok = 1'b0;
        fd = $fopen("sim/mem_stage_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                t.id, t.op, inst_w, t.pc, t.alu, t.src2, t.wbv, wbinst_w,
                                t.wbdata, t.rdata, t.dly, t.bp, t.we, t.wdata, t.mwdata,
                                t.strb);
                    t.inst   = inst_w;
                    t.wbinst = wbinst_w;
                    if (n == 16)
                        ops.push_back(t);
                    else
                        $display("trace line skipped, only %0d fields: %s", n, line);
                end
            end
            $fclose(fd);
        end
    endtask

    // results expected while the op is presented downstream
    task automatic check_outputs(input trace_t t);
        logic exp_req;
        logic exp_we;
        exp_req = is_mem_access(t.inst);
        exp_we  = (t.inst.wr.opcode == `RV_STORE);
        check_bit("out_valid", out_valid, 1'b1);
        check_word("out_pc", out_pc, t.pc);
        check_inst("out_inst", out_inst, t.inst);
        check_bit("rd_we", rd_we, t.we);
        check_idx("rd_idx", rd_idx, t.inst);
        check_word("rd_wdata", rd_wdata, t.wdata);
        check_word("mem_wdata", mem_wdata, t.mwdata);
        check_strb("mem_wstrb", mem_wstrb, t.strb);
        check_bit("mem_req", mem_req, exp_req);
        check_bit("mem_we", mem_we, exp_we);
        if (exp_req)
            check_word("mem_addr", mem_addr, t.alu);
    endtask

    // one op: accept, memory response, checks, optional back-pressure
    task automatic run_op(input trace_t t);
        int dly;
        int k;
        int err0;
        err0 = total_errors();
        dly  = (t.dly == RND_DLY) ? ($unsigned($random(seed)) % (MAX_DLY + 1)) : t.dly;
        @(negedge clk);
        in_valid  = 1'b1;
        in_pc     = t.pc;
        in_inst   = t.inst;
        in_op     = t.op;
        in_alu    = t.alu;
        in_src2   = t.src2;
        wb_valid  = t.wbv;
        wb_inst   = t.wbinst;
        wb_wdata  = t.wbdata;
        mem_rdata = t.rdata;
        mem_ack   = 1'b0;
        out_ready = 1'b1;
        #1;
        if (!in_ready) begin
            $display("test %0d: stage did not accept the op", t.id);
            err_cnt++;
        end
        @(negedge clk);                 // op sits in the stage register now
        in_valid  = 1'b0;
        in_pc     = ~t.pc;              // other values, a wrong reload shows up
        in_inst   = ~t.inst;
        in_op     = ~t.op;
        in_alu    = ~t.alu;
        in_src2   = ~t.src2;
        out_ready = (t.bp == 0);
        mem_ack   = (dly == 0);
        k = 0;
        #1;
        while (is_mem_access(t.inst) && !mem_ack) begin   // stall window
            check_bit("in_ready", in_ready, 1'b0);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("rd_we", rd_we, 1'b0);
            check_bit("mem_req", mem_req, 1'b1);
            check_word("mem_addr", mem_addr, t.alu);
            @(negedge clk);
            k++;
            mem_ack = (k >= dly);
            #1;
        end
        check_outputs(t);
        check_bit("in_ready", in_ready, t.bp == 0);
        for (int b = 0; b < t.bp; b++) begin
            @(negedge clk);
            out_ready = (b == t.bp - 1);
            #1;
            check_outputs(t);           // held values
            check_bit("in_ready", in_ready, b == t.bp - 1);
        end
        if (total_errors() == err0) begin
            $display("test %0d ok", t.id);
        end else begin
            $display("test %0d bad", t.id);
            bad_tests++;
        end
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        bit ok;
        rst = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_inst = '0;
        in_op = '0;
        in_alu = '0;
        in_src2 = '0;
        out_ready = 1'b1;
        wb_valid = 1'b0;
        wb_inst = '0;
        wb_wdata = '0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        load_trace(ok);
        if (!ok || ops.size() == 0) begin
            $display("could not read any operation from the trace file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (8) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (ops[i])
                run_op(ops[i]);
            @(negedge clk);
            $display("tests %0d  bad %0d  errors %0d", ops.size(), bad_tests,
                     total_errors());
            if (total_errors() == 0)
                $display("*** PASSED ***");
            else
                $display("*** FAILED ***");
            $finish;
        end
    end

    // watchdog, budget scales with the trace length
    initial begin
        wait (trace_loaded);
        repeat ((ops.size() + 4) * (MAX_DLY + 4 + MAX_BP)) @(posedge clk);
        $display("timeout: the trace did not finish in the expected number of cycles");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== sim/mem_stage_trace.txt ====
# id op inst pc alu src2 wbv wbinst wbdata rdata dly bp | exp: we wdata mwdata strb
# all hex except id, dly ff means random ack delay, bp is back-pressure cycles
1 4000 513 1000 1234 55 0 0 0 0 0 0 1 1234 0 0
2 4 ef 2000 99 0 0 0 0 0 0 0 1 2004 0 0
3 300 e7 3ffc 40 0 0 0 0 0 0 0 1 4000 0 0
4 31 1373 4000 7 abcd 0 0 0 0 0 0 1 abcd 0 0
5 32 2373 4004 8 77 0 0 0 0 0 3 1 77 0 0
6 b 283 5000 100 0 0 0 0 123456789abcdef 1 0 1 ffffffffffffffef 0 0
7 b 283 5004 105 0 0 0 0 123456789abcdef 2 0 1 45 0 0
8 e 283 5008 107 0 0 0 0 123456789abcdef 0 0 1 1 0 0
9 e 283 500c 103 0 0 0 0 123456789abcdef 1 0 1 89 0 0
10 c 283 5010 102 0 0 0 0 123456789abcdef 3 0 1 ffffffffffff89ab 0 0
11 c 283 5014 103 0 0 0 0 123456789abcdef 0 0 1 0 0 0
12 f 283 5018 106 0 0 0 0 123456789abcdef 1 0 1 123 0 0
13 f 283 501c 101 0 0 0 0 123456789abcdef 0 0 1 0 0 0
14 d 283 5020 100 0 0 0 0 123456789abcdef 2 0 1 ffffffff89abcdef 0 0
15 d 283 5024 104 0 0 0 0 123456789abcdef ff 0 1 1234567 0 0
16 29 283 5028 100 0 0 0 0 123456789abcdef 0 0 1 89abcdef 0 0
17 2a 283 502c 108 0 0 0 0 123456789abcdef ff 2 1 123456789abcdef 0 0
18 10 600023 6000 203 1122334455667788 0 0 0 0 1 0 0 0 88000000 08
19 11 600023 6004 206 1122334455667788 0 0 0 0 0 0 0 0 7788000000000000 c0
20 11 600023 6008 205 1122334455667788 0 0 0 0 1 0 0 0 0 00
21 12 600023 600c 204 1122334455667788 0 0 0 0 2 0 0 0 5566778800000000 f0
22 12 600023 6010 200 1122334455667788 0 0 0 0 0 0 0 0 55667788 0f
23 2b 600023 6014 208 1122334455667788 0 0 0 0 ff 0 0 0 1122334455667788 ff
24 2b 600023 7000 210 1111 1 333 2222 0 1 0 0 0 2222 ff
25 2b 600023 7004 210 1111 1 363 2222 0 0 0 0 0 1111 ff
26 2b 600023 7008 210 1111 1 3b3 2222 0 2 0 0 0 1111 ff
27 2b 23 700c 210 1111 1 33 2222 0 0 0 0 0 1111 ff
28 2b 600023 7010 210 1111 0 333 2222 0 1 0 0 0 1111 ff
29 2b 600023 7014 210 1111 1 1373 2222 0 ff 0 0 0 2222 ff
